// ==== design/dispatch_ctrl.sv ====
// dispatch gating and halt status
// status holds the first halt or illegal retirement until reset
// stall is combinational on the current dest register

`timescale 1ns/1ps
`include "rename_params.svh"

module dispatch_ctrl (
	input	logic						clk,
	input	logic						rst_n_i,
	input	logic						dispatch_i,
	input	rename_pkg::areg_t			dest_areg_i,
	input	logic						rob_full_i,
	input	logic						free_empty_i,
	input	logic						retire_en_i,
	input	rename_pkg::inst_kind_t		retire_kind_i,
	output	logic						stall_o,
	output	logic						accept_o,
	output	logic						alloc_o,
	output	rename_pkg::error_status_t	error_status_o
);

	rename_pkg::error_status_t	status_q;
	logic						halted;
	logic						has_dest;
	logic						fl_stall;

	assign halted	= (status_q != rename_pkg::NO_ERROR);
	assign has_dest	= (dest_areg_i != `ZERO_REG);	// zero reg takes no preg
	assign fl_stall	= free_empty_i & has_dest;		// only matters with a dest

	assign stall_o	= rob_full_i | fl_stall | halted;
	assign accept_o	= dispatch_i & ~stall_o;
	assign alloc_o	= accept_o & has_dest;			// pops the free list

	// latch first halt/illegal at its retire edge
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			status_q <= rename_pkg::NO_ERROR;
		end else if (retire_en_i && !halted) begin
			case (retire_kind_i)
				rename_pkg::KIND_HALT:		status_q <= rename_pkg::HALTED_ON_HALT;
				rename_pkg::KIND_ILLEGAL:	status_q <= rename_pkg::HALTED_ON_ILLEGAL;
				default:					status_q <= status_q;
			endcase
		end
	end

	assign error_status_o = status_q;

endmodule

// ==== design/free_list.sv ====
// circular FIFO of free physical registers
// holds pregs NUM_AREG..NUM_PREG-1 ascending after reset
// caller must not pop when empty, push can never overflow

`timescale 1ns/1ps
`include "rename_params.svh"

module free_list (
	input	logic					clk,
	input	logic					rst_n_i,
	input	logic					alloc_i,			// pop head
	input	logic					release_i,			// push tail
	input	rename_pkg::preg_t		release_preg_i,
	output	rename_pkg::preg_t		free_preg_o,
	output	logic					free_empty_o
);

	localparam int FL_DEPTH	= `NUM_PREG - `NUM_AREG;
	localparam int FL_PTR_W	= $clog2(FL_DEPTH);

	rename_pkg::preg_t		fifo_q [FL_DEPTH];
	logic [FL_PTR_W-1:0]	head_q;
	logic [FL_PTR_W-1:0]	tail_q;
	logic [FL_PTR_W:0]		count_q;		// 0..FL_DEPTH

	assign free_preg_o	= fifo_q[head_q];
	assign free_empty_o	= (count_q == '0);

	// ============================================================
	// storage, reset fills it with the spare pregs
	// ============================================================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < FL_DEPTH; i++) begin
				fifo_q[i] <= rename_pkg::preg_t'(`NUM_AREG + i);
			end
		end else if (release_i) begin
			fifo_q[tail_q] <= release_preg_i;	// head read happens before the edge
		end
	end

	// ============================================================
	// pointers and count
	// ============================================================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			head_q	<= '0;
			tail_q	<= '0;		// full, tail meets head
			count_q	<= (FL_PTR_W+1)'(FL_DEPTH);
		end else begin
			if (alloc_i) begin
				head_q <= (head_q == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : head_q + 1'b1;
			end
			if (release_i) begin
				tail_q <= (tail_q == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : tail_q + 1'b1;
			end
			// pop and push together leave count alone
			case ({alloc_i, release_i})
				2'b10:		count_q <= count_q - 1'b1;
				2'b01:		count_q <= count_q + 1'b1;
				default:	count_q <= count_q;
			endcase
		end
	end

endmodule

// ==== design/map_table.sv ====
// architectural to physical map with one ready bit per preg
// reads show state before the edge, no bypass from the broadcast
// reset maps areg i to preg i, pregs 0..NUM_AREG-1 ready

`timescale 1ns/1ps
`include "rename_params.svh"

module map_table (
	input	logic					clk,
	input	logic					rst_n_i,
	input	logic					accept_i,
	input	logic					alloc_i,
	input	rename_pkg::areg_t		dest_areg_i,
	input	rename_pkg::areg_t		opa_areg_i,
	input	rename_pkg::areg_t		opb_areg_i,
	input	rename_pkg::preg_t		new_preg_i,		// free list head
	input	logic					cdb_vld_i,
	input	rename_pkg::preg_t		cdb_preg_i,
	output	rename_pkg::preg_t		opa_preg_o,
	output	rename_pkg::preg_t		opb_preg_o,
	output	rename_pkg::preg_t		old_preg_o,		// to rob, freed on retire
	output	logic					opa_rdy_o,
	output	logic					opb_rdy_o
);

	rename_pkg::preg_t		map_q [`NUM_AREG];
	logic [`NUM_PREG-1:0]	rdy_q;
	logic					remap;

	assign remap = accept_i & alloc_i;	// accepted with a real dest

	// ============================================================
	// lookups
	// ============================================================
	assign opa_preg_o = map_q[opa_areg_i];	// old mapping even if src == dest
	assign opb_preg_o = map_q[opb_areg_i];
	assign old_preg_o = map_q[dest_areg_i];

	// zero reg always reads ready
	assign opa_rdy_o = rdy_q[opa_preg_o] | (opa_areg_i == `ZERO_REG);
	assign opb_rdy_o = rdy_q[opb_preg_o] | (opb_areg_i == `ZERO_REG);

	// ============================================================
	// map update
	// ============================================================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `NUM_AREG; i++) begin
				map_q[i] <= rename_pkg::preg_t'(i);	// identity map
			end
		end else if (remap) begin
			map_q[dest_areg_i] <= new_preg_i;
		end
	end

	// ready bits
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `NUM_PREG; i++) begin
				rdy_q[i] <= (i < `NUM_AREG);
			end
		end else begin
			if (cdb_vld_i) begin
				rdy_q[cdb_preg_i] <= 1'b1;		// result broadcast
			end
			// new preg is free, never the one being broadcast
			if (remap) begin
				rdy_q[new_preg_i] <= 1'b0;
			end
		end
	end

endmodule

// ==== design/rename_core.sv ====
// rename and retire slice of an out-of-order core
// takes decoded instructions, completion arrives as a ROB index strobe
// dispatch outputs reflect state before the edge, no back-pressure beyond stall_o

`timescale 1ns/1ps

module rename_core (
	input	logic						clk,
	input	logic						rst_n_i,
	// dispatch
	input	logic						dispatch_i,
	input	rename_pkg::areg_t			dest_areg_i,
	input	rename_pkg::areg_t			opa_areg_i,
	input	rename_pkg::areg_t			opb_areg_i,
	input	rename_pkg::inst_kind_t		kind_i,
	// completion
	input	logic						complete_i,
	input	rename_pkg::rob_idx_t		complete_idx_i,

	output	logic						stall_o,
	output	rename_pkg::rob_idx_t		rob_idx_o,
	output	rename_pkg::preg_t			dest_preg_o,		// free list head
	output	rename_pkg::preg_t			opa_preg_o,
	output	rename_pkg::preg_t			opb_preg_o,
	output	logic						opa_rdy_o,
	output	logic						opb_rdy_o,
	output	logic						retire_vld_o,
	output	rename_pkg::areg_t			retire_areg_o,
	output	rename_pkg::preg_t			retire_preg_o,
	output	rename_pkg::error_status_t	error_status_o
);

	logic						accept;
	logic						alloc;
	logic						free_empty;
	logic						rob_full;
	rename_pkg::preg_t			old_preg;		// map -> rob
	logic						release_en;
	rename_pkg::preg_t			release_preg;	// rob -> free list
	rename_pkg::inst_kind_t		retire_kind;
	logic						cdb_vld;
	rename_pkg::preg_t			cdb_preg;

	// ============================================================
	// dispatch gating
	// ============================================================
	dispatch_ctrl dispatch_ctrl0 (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.dispatch_i		(dispatch_i),
		.dest_areg_i	(dest_areg_i),
		.rob_full_i		(rob_full),
		.free_empty_i	(free_empty),
		.retire_en_i	(retire_vld_o),
		.retire_kind_i	(retire_kind),
		.stall_o		(stall_o),
		.accept_o		(accept),
		.alloc_o		(alloc),
		.error_status_o	(error_status_o)
	);

	// ============================================================
	// rename state
	// ============================================================
	map_table map_table0 (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.accept_i		(accept),
		.alloc_i		(alloc),
		.dest_areg_i	(dest_areg_i),
		.opa_areg_i		(opa_areg_i),
		.opb_areg_i		(opb_areg_i),
		.new_preg_i		(dest_preg_o),
		.cdb_vld_i		(cdb_vld),
		.cdb_preg_i		(cdb_preg),
		.opa_preg_o		(opa_preg_o),
		.opb_preg_o		(opb_preg_o),
		.old_preg_o		(old_preg),
		.opa_rdy_o		(opa_rdy_o),
		.opb_rdy_o		(opb_rdy_o)
	);

	free_list free_list0 (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.alloc_i		(alloc),
		.release_i		(release_en),
		.release_preg_i	(release_preg),
		.free_preg_o	(dest_preg_o),
		.free_empty_o	(free_empty)
	);

	// ============================================================
	// reorder buffer
	// ============================================================
	rob rob0 (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.accept_i		(accept),
		.alloc_i		(alloc),
		.dest_areg_i	(dest_areg_i),
		.new_preg_i		(dest_preg_o),
		.old_preg_i		(old_preg),
		.kind_i			(kind_i),
		.complete_i		(complete_i),
		.complete_idx_i	(complete_idx_i),
		.tail_idx_o		(rob_idx_o),
		.rob_full_o		(rob_full),
		.retire_vld_o	(retire_vld_o),
		.retire_areg_o	(retire_areg_o),
		.retire_preg_o	(retire_preg_o),
		.release_o		(release_en),
		.release_preg_o	(release_preg),
		.retire_kind_o	(retire_kind),
		.cdb_vld_o		(cdb_vld),
		.cdb_preg_o		(cdb_preg)
	);

endmodule

// ==== design/rename_params.svh ====
// sizing for the rename and retire slice
// ROB_DEPTH must stay a power of two, pointers wrap by overflow
// NUM_PREG - NUM_AREG sets the free list depth, also a power of two

`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// ============================================================
// register file sizes
// ============================================================
`define NUM_AREG	32			// architectural registers
`define NUM_PREG	40			// physical registers, 8 spare after reset
`define ZERO_REG	5'd31		// never renamed, always ready

// ============================================================
// index widths
// ============================================================
`define AREG_W		5
`define PREG_W		6
`define ROB_DEPTH	16
`define ROB_IDX_W	4

`endif

// ==== design/rename_pkg.sv ====
// shared index types and encodings for the rename slice
// widths come from the params header

`include "rename_params.svh"

package rename_pkg;

	// register and slot indices
	typedef logic [`AREG_W-1:0]		areg_t;
	typedef logic [`PREG_W-1:0]		preg_t;
	typedef logic [`ROB_IDX_W-1:0]	rob_idx_t;

	// ============================================================
	// decoded instruction kind
	// ============================================================
	typedef enum logic [1:0] {
		KIND_NORMAL		= 2'd0,
		KIND_HALT		= 2'd1,		// stops dispatch once retired
		KIND_ILLEGAL	= 2'd2		// same, reported as illegal
	} inst_kind_t;

	// ============================================================
	// core status, 4 bits like the full core's status port
	// ============================================================
	typedef enum logic [3:0] {
		NO_ERROR			= 4'h0,
		HALTED_ON_HALT		= 4'h1,
		HALTED_ON_ILLEGAL	= 4'h2
	} error_status_t;

endpackage

// ==== design/rob.sv ====
// in-order reorder buffer, one dispatch and one retire per cycle
// completion index must name an entry in flight
// ROB_DEPTH power of two, pointers carry an extra wrap bit

`timescale 1ns/1ps
`include "rename_params.svh"

module rob (
	input	logic						clk,
	input	logic						rst_n_i,
	// dispatch side
	input	logic						accept_i,
	input	logic						alloc_i,
	input	rename_pkg::areg_t			dest_areg_i,
	input	rename_pkg::preg_t			new_preg_i,
	input	rename_pkg::preg_t			old_preg_i,
	input	rename_pkg::inst_kind_t		kind_i,
	// completion strobe
	input	logic						complete_i,
	input	rename_pkg::rob_idx_t		complete_idx_i,

	output	rename_pkg::rob_idx_t		tail_idx_o,
	output	logic						rob_full_o,
	// retirement
	output	logic						retire_vld_o,
	output	rename_pkg::areg_t			retire_areg_o,
	output	rename_pkg::preg_t			retire_preg_o,
	output	logic						release_o,
	output	rename_pkg::preg_t			release_preg_o,
	output	rename_pkg::inst_kind_t		retire_kind_o,
	// result broadcast to the ready bits
	output	logic						cdb_vld_o,
	output	rename_pkg::preg_t			cdb_preg_o
);

	logic [`ROB_IDX_W:0]		head_q;
	logic [`ROB_IDX_W:0]		tail_q;
	rename_pkg::rob_idx_t		head_idx;
	rename_pkg::rob_idx_t		tail_idx;
	logic						empty;

	// per-entry state
	logic [`ROB_DEPTH-1:0]		done_q;
	logic [`ROB_DEPTH-1:0]		alloc_q;		// entry owns a new preg
	rename_pkg::areg_t			dest_q [`ROB_DEPTH];
	rename_pkg::preg_t			new_q [`ROB_DEPTH];
	rename_pkg::preg_t			old_q [`ROB_DEPTH];
	rename_pkg::inst_kind_t		kind_q [`ROB_DEPTH];

	assign head_idx	= head_q[`ROB_IDX_W-1:0];
	assign tail_idx	= tail_q[`ROB_IDX_W-1:0];

	// same slot, wrap bits tell full from empty
	assign empty		= (head_q == tail_q);
	assign rob_full_o	= (head_idx == tail_idx) && (head_q[`ROB_IDX_W] != tail_q[`ROB_IDX_W]);
	assign tail_idx_o	= tail_idx;

	// ============================================================
	// retirement, head leaves at the end of this cycle
	// ============================================================
	assign retire_vld_o		= ~empty & done_q[head_idx];
	assign retire_areg_o	= dest_q[head_idx];
	assign retire_preg_o	= new_q[head_idx];
	assign release_o		= retire_vld_o & alloc_q[head_idx];	// old preg back to free list
	assign release_preg_o	= old_q[head_idx];
	assign retire_kind_o	= kind_q[head_idx];

	// broadcast only when there is a dest
	assign cdb_vld_o	= complete_i & alloc_q[complete_idx_i];
	assign cdb_preg_o	= new_q[complete_idx_i];

	// ============================================================
	// pointers and done bits
	// ============================================================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			head_q	<= '0;
			tail_q	<= '0;
			done_q	<= '0;
		end else begin
			if (accept_i) begin
				tail_q				<= tail_q + 1'b1;
				done_q[tail_idx]	<= 1'b0;	// fresh entry
			end
			if (complete_i) begin
				done_q[complete_idx_i] <= 1'b1;
			end
			if (retire_vld_o) begin
				head_q <= head_q + 1'b1;
			end
		end
	end

	// entry payload, written at the tail
	always_ff @(posedge clk) begin
		if (accept_i) begin
			alloc_q[tail_idx]	<= alloc_i;
			dest_q[tail_idx]	<= dest_areg_i;
			new_q[tail_idx]		<= new_preg_i;
			old_q[tail_idx]		<= old_preg_i;
			kind_q[tail_idx]	<= kind_i;
		end
	end

endmodule

// ==== filelist.f ====
+incdir+design
design/rename_pkg.sv
design/dispatch_ctrl.sv
design/map_table.sv
design/free_list.sv
design/rob.sv
design/rename_core.sv
testbench/rename_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rename core testbench with Verilator, log goes to sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module rename_core_tb -o rename_core_sim
./obj_dir/rename_core_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "Verification passed" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"

// ==== testbench/rename_core_tb.sv ====
// self-checking testbench, stim and expected stall come from testbench/rename_stim.txt
// a reference model of map, ready bits, free list and ROB predicts every output
// run from the project root so the stim path resolves

`timescale 1ns/1ps
`include "rename_params.svh"

module rename_core_tb;

	logic						clk, rst_n_i, dispatch_i, complete_i;
	logic						stall_o, opa_rdy_o, opb_rdy_o, retire_vld_o;
	rename_pkg::areg_t			dest_areg_i, opa_areg_i, opb_areg_i, retire_areg_o;
	rename_pkg::preg_t			dest_preg_o, opa_preg_o, opb_preg_o, retire_preg_o;
	rename_pkg::inst_kind_t		kind_i;
	rename_pkg::rob_idx_t		complete_idx_i, rob_idx_o;
	rename_pkg::error_status_t	error_status_o;

	// stim columns, one entry per file line
	byte	op_q [$];
	int		test_q [$], dest_q [$], opa_q [$], opb_q [$];
	int		kind_q [$], idx_q [$], stall_q [$], reps_q [$];

	// ============================================================
	// reference model state
	// ============================================================
	int		m_map [`NUM_AREG];
	bit		m_rdy [`NUM_PREG];
	int		m_fl [$];			// free list, head at index 0
	int		m_dest [`ROB_DEPTH], m_new [`ROB_DEPTH];
	int		m_old [`ROB_DEPTH], m_kind [`ROB_DEPTH];
	bit		m_alloc [`ROB_DEPTH], m_done [`ROB_DEPTH];
	int		m_head, m_count, m_status;
	int		checks, errors, tests, total_ops, limit_cycles;

	rename_core dut0 (.*);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input int actual, input int expected);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic report_test(input int num, input int errs);
		tests++;
		$display("test %0d finished, %0d errors", num, errs);
	endtask

	task automatic load_stim(output bit ok);
		int		fd;
		int		cnt;
		string	line;
		byte	op;
		int		t, d, a, b, k, ci, s, n;
		ok = 1'b0;
		fd = $fopen("testbench/rename_stim.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) > 0) begin
				cnt = $sscanf(line, "%c %d %h %h %h %d %d %d %d", op, t, d, a, b, k, ci, s, n);
				if (cnt == 9 && op != "#") begin	// comment and blank lines drop out here
					op_q.push_back(op);
					test_q.push_back(t);
					dest_q.push_back(d);
					opa_q.push_back(a);
					opb_q.push_back(b);
					kind_q.push_back(k);
					idx_q.push_back(ci);
					stall_q.push_back(s);
					reps_q.push_back(n);
					total_ops += n;
				end
			end
			$fclose(fd);
			ok = (op_q.size() > 0);
		end
	endtask

	// state right after reset: identity map, spare pregs free in order
	task automatic reset_model();
		m_fl.delete();
		for (int i = 0; i < `NUM_AREG; i++) begin
			m_map[i] = i;
		end
		for (int i = 0; i < `NUM_PREG; i++) begin
			m_rdy[i] = (i < `NUM_AREG);
			if (i >= `NUM_AREG) begin
				m_fl.push_back(i);
			end
		end
		for (int i = 0; i < `ROB_DEPTH; i++) begin
			m_done[i]	= 1'b0;
			m_alloc[i]	= 1'b0;
		end
		m_head		= 0;
		m_count		= 0;
		m_status	= int'(rename_pkg::NO_ERROR);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		dispatch_i	= 1'b0;
		complete_i	= 1'b0;
		rst_n_i		= 1'b0;
		repeat (8) @(negedge clk);
		rst_n_i		= 1'b1;
		reset_model();
	endtask

	// ============================================================
	// one cycle: drive on the falling edge, check 1 ns before the rising edge
	// ============================================================
	task automatic run_cycle(input bit disp, input int d, input int a, input int b, input int k,
			input bit comp, input int idx, input int file_stall);
		int		tail;
		bit		has_dest;
		bit		exp_stall;
		bit		ret;
		@(negedge clk);
		dispatch_i		= disp;
		dest_areg_i		= rename_pkg::areg_t'(d);
		opa_areg_i		= rename_pkg::areg_t'(a);
		opb_areg_i		= rename_pkg::areg_t'(b);
		kind_i			= rename_pkg::inst_kind_t'(k);
		complete_i		= comp;
		complete_idx_i	= rename_pkg::rob_idx_t'(idx);
		#4;
		tail		= (m_head + m_count) % `ROB_DEPTH;
		has_dest	= (d != int'(`ZERO_REG));
		exp_stall	= (m_count == `ROB_DEPTH) || (m_status != 0) || (has_dest && m_fl.size() == 0);
		ret			= (m_count > 0) && m_done[m_head];	// head done, leaves this cycle
		check_value("stall_o", int'(stall_o), int'(exp_stall));
		if (file_stall >= 0) begin
			check_value("stall_o (stim column)", int'(stall_o), file_stall);
		end
		check_value("retire_vld_o", int'(retire_vld_o), int'(ret));
		check_value("error_status_o", int'(error_status_o), m_status);
		if (ret) begin
			check_value("retire_areg_o", int'(retire_areg_o), m_dest[m_head]);
			if (m_alloc[m_head]) begin
				check_value("retire_preg_o", int'(retire_preg_o), m_new[m_head]);
			end
		end
		if (disp) begin
			check_value("rob_idx_o", int'(rob_idx_o), tail);
			if (has_dest && m_fl.size() > 0) begin
				check_value("dest_preg_o", int'(dest_preg_o), m_fl[0]);
			end
			// sources see the mapping before this edge
			check_value("opa_preg_o", int'(opa_preg_o), m_map[a]);
			check_value("opb_preg_o", int'(opb_preg_o), m_map[b]);
			check_value("opa_rdy_o", int'(opa_rdy_o), int'(m_rdy[m_map[a]] || a == 31));
			check_value("opb_rdy_o", int'(opb_rdy_o), int'(m_rdy[m_map[b]] || b == 31));
		end
		// model moves to the state after the rising edge
		if (comp) begin
			m_done[idx] = 1'b1;
			if (m_alloc[idx]) begin
				m_rdy[m_new[idx]] = 1'b1;	// completion broadcast
			end
		end
		if (disp && !exp_stall) begin
			m_dest[tail]	= d;
			m_kind[tail]	= k;
			m_done[tail]	= 1'b0;
			m_alloc[tail]	= has_dest;
			m_old[tail]		= m_map[d];
			if (has_dest) begin
				m_new[tail]			= m_fl.pop_front();
				m_map[d]			= m_new[tail];
				m_rdy[m_new[tail]]	= 1'b0;
			end
			m_count++;
		end
		if (ret) begin
			if (m_alloc[m_head]) begin
				m_fl.push_back(m_old[m_head]);	// old preg back at the tail
			end
			if (m_status == 0 && m_kind[m_head] == int'(rename_pkg::KIND_HALT)) begin
				m_status = int'(rename_pkg::HALTED_ON_HALT);
			end else if (m_status == 0 && m_kind[m_head] == int'(rename_pkg::KIND_ILLEGAL)) begin
				m_status = int'(rename_pkg::HALTED_ON_ILLEGAL);
			end
			m_head = (m_head + 1) % `ROB_DEPTH;
			m_count--;
		end
		@(posedge clk);
	endtask

	task automatic run_stim();
		int		cur_test;
		int		err_base;
		bit		disp;
		bit		comp;
		cur_test	= test_q[0];
		err_base	= errors;
		foreach (op_q[i]) begin
			if (test_q[i] != cur_test) begin
				report_test(cur_test, errors - err_base);
				cur_test	= test_q[i];
				err_base	= errors;
			end
			disp = (op_q[i] == "D");
			comp = (op_q[i] == "C");
			if (op_q[i] == "R") begin
				apply_reset();
			end else begin
				repeat (reps_q[i]) begin
					run_cycle(disp, dest_q[i], opa_q[i], opb_q[i], kind_q[i], comp, idx_q[i],
						disp ? stall_q[i] : -1);
				end
			end
			// idle gap of 0..2 cycles
			repeat ($urandom % 3) begin
				run_cycle(1'b0, 31, 31, 31, 0, 1'b0, 0, -1);
			end
		end
		report_test(cur_test, errors - err_base);
	endtask

	// ============================================================
	// main sequence and watchdog
	// ============================================================
	initial begin
		bit		loaded;
		clk				= 1'b0;
		rst_n_i			= 1'b0;
		dispatch_i		= 1'b0;
		complete_i		= 1'b0;
		dest_areg_i		= '0;
		opa_areg_i		= '0;
		opb_areg_i		= '0;
		kind_i			= rename_pkg::KIND_NORMAL;
		complete_idx_i	= '0;
		void'($urandom(32'h1897));
		load_stim(loaded);
		limit_cycles = 20 * total_ops + 8;
		if (!loaded) begin
			$display("stim file testbench/rename_stim.txt is missing or empty");
			$display("Verification failed");
		end else begin
			apply_reset();
			run_stim();
			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			if (errors == 0) begin
				$display("Verification passed");
			end else begin
				$display("Verification failed");
			end
		end
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== testbench/rename_stim.txt ====
# op test dest opa opb kind cidx stall reps (regs hex, others decimal)
# op D dispatch C complete I idle R reset, kind 0 normal 1 halt 2 illegal, stall checked on D
D 1 01 02 03 0 0 0 1
D 1 02 01 02 0 0 0 1
D 1 1f 01 1f 0 0 0 1
D 1 03 03 1f 0 0 0 1
R 2 1f 1f 1f 0 0 0 1
D 2 04 05 06 0 0 0 1
D 2 07 04 1f 0 0 0 1
C 2 1f 1f 1f 0 0 0 1
D 2 08 04 07 0 0 0 1
C 2 1f 1f 1f 0 1 0 1
D 2 09 07 04 0 0 0 1
R 3 1f 1f 1f 0 0 0 1
D 3 01 1f 1f 0 0 0 1
D 3 02 1f 1f 0 0 0 1
D 3 03 1f 1f 0 0 0 1
C 3 1f 1f 1f 0 2 0 1
C 3 1f 1f 1f 0 1 0 1
I 3 1f 1f 1f 0 0 0 2
C 3 1f 1f 1f 0 0 0 1
I 3 1f 1f 1f 0 0 0 4
D 3 04 1f 1f 0 0 0 5
D 3 05 01 02 0 0 0 3
R 4 1f 1f 1f 0 0 0 1
D 4 01 1f 1f 0 0 0 8
D 4 02 1f 1f 0 0 1 1
D 4 1f 1f 1f 0 0 0 1
C 4 1f 1f 1f 0 0 0 1
I 4 1f 1f 1f 0 0 0 1
D 4 02 01 1f 0 0 0 1
R 5 1f 1f 1f 0 0 0 1
D 5 1f 1f 1f 0 0 0 15
D 5 01 1f 1f 0 0 0 1
D 5 1f 1f 1f 0 0 1 1
D 5 02 1f 1f 0 0 1 1
C 5 1f 1f 1f 0 0 0 1
I 5 1f 1f 1f 0 0 0 1
D 5 1f 1f 1f 0 0 0 1
R 6 1f 1f 1f 0 0 0 1
D 6 01 01 1f 1 0 0 1
C 6 1f 1f 1f 0 0 0 1
I 6 1f 1f 1f 0 0 0 1
D 6 02 1f 1f 0 0 1 2
R 6 1f 1f 1f 0 0 0 1
D 6 1f 1f 1f 2 0 0 1
C 6 1f 1f 1f 0 0 0 1
I 6 1f 1f 1f 0 0 0 1
D 6 03 1f 1f 0 0 1 1
